// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dispatchTb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== all.f ====
rtl/dispatchPkg.sv
rtl/branchMaskUpdate.sv
rtl/resourceCheck.sv
rtl/dispatchPacketizer.sv
rtl/dispatchTop.sv
bench/dispatchChecker.sv
bench/dispatchTb.sv

// ==== bench/dispatchChecker.sv ====
// Concurrent assertions on dispatch ready, stall and valid, bound to the dispatch top level
`timescale 1ns/1ps

module dispatchChecker (
  input logic clk,
  input logic rstN_i,
  input logic backEndReady_i,
  input logic stallFrontEnd_i,
  input logic dispatchValid_i
);

  int failCount = 0;  // Failed assertion count

  // Ready already excludes a resource stall
  readyStallExclusive: assert property (
    @(posedge clk) disable iff (!rstN_i) !(backEndReady_i && stallFrontEnd_i)
  ) else begin
    $error("backEndReady and stallFrontEnd high in the same cycle");
    failCount++;
  end

  validFollowsReady: assert property (
    @(posedge clk) disable iff (!rstN_i) dispatchValid_i |-> $past(backEndReady_i)
  ) else begin
    $error("dispatchValid without backEndReady on the cycle before");
    failCount++;
  end

  // Valid register is cleared asynchronously
  validLowInReset: assert property (
    @(posedge clk) !rstN_i |-> !dispatchValid_i
  ) else begin
    $error("dispatchValid high during reset");
    failCount++;
  end

endmodule

// ==== bench/dispatchTb.sv ====
// Dispatch stage testbench with directed test tasks, typed compare tasks and the final report
`timescale 1ns/1ps

module dispatchTb import dispatchPkg::*; ();

  localparam int DispatchWidth   = 4;
  localparam int LsqDepth        = 32;
  localparam int IssueQDepth     = 32;
  localparam int ActiveListDepth = 64;

  logic                    clk;
  logic                    rstN;
  renamedPacketT           renamedPacket [DispatchWidth];
  logic                    renameReady;
  logic                    flagRecoverEx;
  ctrlVerifyT              ctrlVerify;
  occupancyT               occupancy;
  issueQPacketT            issueQPacket [DispatchWidth];
  alPacketT                alPacket [DispatchWidth];
  lsqPacketT               lsqPacket [DispatchWidth];
  logic                    dispatchValid;
  logic [CheckpointsC-1:0] updatedBranchMask [DispatchWidth];
  logic                    backEndReady;
  logic                    stallFrontEnd;
  int                      errors;
  int                      timeouts;
  int                      assertFails;
  renamedPacketT           lastGrp [DispatchWidth];  // Group the packet registers should hold
  ctrlVerifyT              lastVerify;

  dispatchTop u_dispatchTop (
    .clk(clk), .rstN_i(rstN), .renamedPacket_i(renamedPacket), .renameReady_i(renameReady),
    .flagRecoverEx_i(flagRecoverEx), .ctrlVerify_i(ctrlVerify), .occupancy_i(occupancy),
    .issueQPacket_o(issueQPacket), .alPacket_o(alPacket), .lsqPacket_o(lsqPacket),
    .dispatchValid_o(dispatchValid), .updatedBranchMask_o(updatedBranchMask),
    .backEndReady_o(backEndReady), .stallFrontEnd_o(stallFrontEnd)
  );

  bind dispatchTop dispatchChecker u_dispatchChecker (
    .clk(clk), .rstN_i(rstN_i), .backEndReady_i(backEndReady_o),
    .stallFrontEnd_i(stallFrontEnd_o), .dispatchValid_i(dispatchValid_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  function automatic logic [CheckpointsC-1:0] maskAfterVerify(
      logic [CheckpointsC-1:0] mask, ctrlVerifyT v);
    logic [CheckpointsC-1:0] m;
    m = mask;
    if (v.valid)
      m[v.checkpoint] = 1'b0;
    return m;
  endfunction

  // archDest is the top field, the rest lines up with the issue packet
  function automatic issueQPacketT expIssue(renamedPacketT p, ctrlVerifyT v);
    issueQPacketT q;
    q = p[$bits(issueQPacketT)-1:0];
    q.branchMask = maskAfterVerify(p.branchMask, v);
    return q;
  endfunction

  function automatic alPacketT expAl(renamedPacketT p);
    return '{isLoad: p.isLoad, isStore: p.isStore, pc: p.pc, archDest: p.archDest,
             physDest: p.physDest, physOldDest: p.physOldDest, destValid: p.destValid};
  endfunction

  function automatic lsqPacketT expLsq(renamedPacketT p, ctrlVerifyT v);
    return '{branchMask: maskAfterVerify(p.branchMask, v), isStore: p.isStore,
             isLoad: p.isLoad};
  endfunction

  function automatic renamedPacketT randPacket();
    logic [127:0]  raw;
    renamedPacketT p;
    raw = {$urandom(), $urandom(), $urandom(), $urandom()};
    p = raw[$bits(renamedPacketT)-1:0];
    p.instClass = instClassE'(3'($urandom_range(4, 0)));  // Legal classes only
    return p;
  endfunction

  function automatic logic expectStall(occupancyT o, renamedPacketT grp [DispatchWidth]);
    int loads;
    int stores;
    loads = 0;
    stores = 0;
    for (int i = 0; i < DispatchWidth; i++) begin
      loads += int'(grp[i].isLoad);
      stores += int'(grp[i].isStore);
    end
    return (int'(o.loadQueueCnt) + loads > LsqDepth) ||
           (int'(o.storeQueueCnt) + stores > LsqDepth) ||
           (int'(o.issueQueueCnt) + DispatchWidth > IssueQDepth) ||
           (int'(o.activeListCnt) + DispatchWidth > ActiveListDepth);
  endfunction

  task automatic checkIssue(issueQPacketT got, issueQPacketT exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s issue packet got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkAl(alPacketT got, alPacketT exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s active list packet got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkLsq(lsqPacketT got, lsqPacketT exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s LSQ packet got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkMask(logic [CheckpointsC-1:0] got, logic [CheckpointsC-1:0] exp,
                           string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s mask got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkBit(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #2;  // Drive point after the edge
  endtask

  task automatic waitReady(int maxCycles);
    int n;
    n = 0;
    while (backEndReady !== 1'b1 && n < maxCycles) begin
      nextCycle();
      #1;
      n++;
    end
    if (backEndReady !== 1'b1) begin
      $display("Timeout: backEndReady stayed low for %0d cycles", maxCycles);
      timeouts++;
    end
  endtask

  task automatic checkPackets(renamedPacketT grp [DispatchWidth], ctrlVerifyT v,
                              string what);
    for (int i = 0; i < DispatchWidth; i++) begin
      checkIssue(issueQPacket[i], expIssue(grp[i], v), what);
      checkAl(alPacket[i], expAl(grp[i]), what);
      checkLsq(lsqPacket[i], expLsq(grp[i], v), what);
    end
  endtask

  task automatic checkDispatched(renamedPacketT grp [DispatchWidth], ctrlVerifyT v,
                                 string what);
    checkBit(dispatchValid, 1'b1, {what, " valid"});
    checkPackets(grp, v, what);
    lastGrp = grp;
    lastVerify = v;
  endtask

  // One random group in, masks checked now, packets checked after the capture edge
  task automatic dispatchGroup(ctrlVerifyT v, string what);
    renamedPacketT grp [DispatchWidth];
    for (int i = 0; i < DispatchWidth; i++) begin
      grp[i] = randPacket();
      grp[i].branchMask[v.checkpoint] = 1'b1;  // So a clear always shows
    end
    renamedPacket = grp;
    ctrlVerify = v;
    renameReady = 1'b1;
    #1;
    checkBit(backEndReady, 1'b1, {what, " ready"});
    for (int i = 0; i < DispatchWidth; i++)
      checkMask(updatedBranchMask[i], maskAfterVerify(grp[i].branchMask, v), what);
    waitReady(8);
    nextCycle();
    checkDispatched(grp, v, what);
  endtask

  task automatic testResetIdle();
    for (int i = 0; i < DispatchWidth; i++)
      renamedPacket[i] = randPacket();
    checkBit(dispatchValid, 1'b0, "valid after reset");
    for (int i = 0; i < DispatchWidth; i++) begin
      checkIssue(issueQPacket[i], '0, "reset");
      checkAl(alPacket[i], '0, "reset");
      checkLsq(lsqPacket[i], '0, "reset");
    end
    repeat (5) begin
      nextCycle();
      checkBit(dispatchValid, 1'b0, "idle valid");
      checkBit(backEndReady, 1'b0, "idle ready");
    end
  endtask

  task automatic testBasicDispatch();
    occupancy.loadQueueCnt  = CountW'($urandom_range(8, 0));
    occupancy.storeQueueCnt = CountW'($urandom_range(8, 0));
    occupancy.issueQueueCnt = CountW'($urandom_range(8, 0));
    occupancy.activeListCnt = CountW'($urandom_range(8, 0));
    for (int g = 0; g < 6; g++)
      dispatchGroup('0, "basic");  // Back to back
    renameReady = 1'b0;
    nextCycle();
    checkBit(dispatchValid, 1'b0, "valid after last group");
  endtask

  task automatic testBranchVerify();
    ctrlVerifyT v;
    occupancy = '0;
    for (int k = 0; k < CheckpointsC; k++) begin
      v.valid = 1'b1;
      v.checkpoint = CheckpointLogW'(k);
      dispatchGroup(v, "verify");
    end
    v.valid = 1'b0;
    v.checkpoint = CheckpointLogW'($urandom_range(7, 0));
    dispatchGroup(v, "no verify");
    renameReady = 1'b0;
    ctrlVerify = '0;
    nextCycle();
  endtask

  task automatic capacityCase(int which, int occ, int nLoads, int nStores, string what);
    renamedPacketT grp [DispatchWidth];
    logic          expStall;
    for (int i = 0; i < DispatchWidth; i++) begin
      grp[i] = randPacket();
      grp[i].isLoad  = (i < nLoads);
      grp[i].isStore = (i >= nLoads) && (i < nLoads + nStores);
    end
    occupancy = '0;
    case (which)
      0:       occupancy.loadQueueCnt  = CountW'(occ);
      1:       occupancy.storeQueueCnt = CountW'(occ);
      2:       occupancy.issueQueueCnt = CountW'(occ);
      default: occupancy.activeListCnt = CountW'(occ);
    endcase
    ctrlVerify = '0;
    renamedPacket = grp;
    renameReady = 1'b1;
    expStall = expectStall(occupancy, grp);
    #1;
    checkBit(stallFrontEnd, expStall, {what, " stall"});
    checkBit(backEndReady, !expStall, {what, " ready"});
    nextCycle();
    checkBit(dispatchValid, !expStall, {what, " valid"});
    if (!expStall)
      checkDispatched(grp, ctrlVerify, what);
    else
      checkPackets(lastGrp, lastVerify, {what, " held"});
  endtask

  task automatic testCapacity();
    capacityCase(0, LsqDepth - 2, 2, 0, "load at limit");
    capacityCase(0, LsqDepth - 2, 3, 0, "load over limit");
    capacityCase(0, 255, 4, 0, "load count wrap");
    capacityCase(1, LsqDepth - 1, 0, 1, "store at limit");
    capacityCase(1, LsqDepth - 1, 1, 2, "store over limit");
    capacityCase(2, IssueQDepth - DispatchWidth, 1, 1, "issue queue at limit");
    capacityCase(2, IssueQDepth - DispatchWidth + 1, 0, 0, "issue queue over limit");
    capacityCase(3, ActiveListDepth - DispatchWidth, 2, 2, "active list at limit");
    capacityCase(3, ActiveListDepth - DispatchWidth + 1, 0, 0, "active list over limit");
    renameReady = 1'b0;
    occupancy = '0;
    nextCycle();
  endtask

  task automatic testRecovery();
    for (int i = 0; i < DispatchWidth; i++)
      renamedPacket[i] = randPacket();
    renameReady = 1'b1;
    flagRecoverEx = 1'b1;  // Mispredict flush in progress
    #1;
    checkBit(backEndReady, 1'b0, "recovery ready");
    checkBit(stallFrontEnd, 1'b0, "recovery stall");
    repeat (4) begin
      nextCycle();
      checkBit(dispatchValid, 1'b0, "recovery valid");
      checkPackets(lastGrp, lastVerify, "recovery held");
    end
    flagRecoverEx = 1'b0;
    renameReady = 1'b0;
  endtask

  initial begin
    void'($urandom(61));
    errors = 0;
    timeouts = 0;
    rstN = 1'b0;
    renameReady = 1'b0;
    flagRecoverEx = 1'b0;
    ctrlVerify = '0;
    occupancy = '0;
    for (int i = 0; i < DispatchWidth; i++)
      renamedPacket[i] = '0;
    repeat (4) @(posedge clk);
    #2;
    rstN = 1'b1;
    testResetIdle();
    testBasicDispatch();
    testBranchVerify();
    testCapacity();
    testRecovery();
    assertFails = u_dispatchTop.u_dispatchChecker.failCount;
    $display("Dispatch run done, %0d errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, assertFails);
    if (errors == 0 && timeouts == 0 && assertFails == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== rtl/branchMaskUpdate.sv ====
// Per-slot branch mask update that clears a verified checkpoint bit
`timescale 1ns/1ps

module branchMaskUpdate import dispatchPkg::*; #(
  parameter int DispatchWidth = 4
) (
  input  renamedPacketT           renamedPacket_i [DispatchWidth],
  input  ctrlVerifyT              ctrlVerify_i,
  output logic [CheckpointsC-1:0] updatedBranchMask_o [DispatchWidth]
);

  logic [CheckpointsC-1:0] clearMask;  // One-hot bit of the resolved branch

  always_comb begin
    clearMask = '0;
    if (ctrlVerify_i.valid) begin
      clearMask[ctrlVerify_i.checkpoint] = 1'b1;
    end
  end

  // A correctly resolved branch no longer guards any younger instruction,
  // so every slot in the group drops that dependency the same way
  always_comb begin
    for (int i = 0; i < DispatchWidth; i++) begin
      updatedBranchMask_o[i] = renamedPacket_i[i].branchMask & ~clearMask;
    end
  end

endmodule

// ==== rtl/dispatchPacketizer.sv ====
// Splits each instruction into issue queue, active list and LSQ packets and registers them
`timescale 1ns/1ps

module dispatchPacketizer import dispatchPkg::*; #(
  parameter int DispatchWidth = 4
) (
  input  logic                    clk,
  input  logic                    rstN_i,
  input  logic                    dispatchEn_i,  // Back end ready, capture group
  input  renamedPacketT           renamedPacket_i [DispatchWidth],
  input  logic [CheckpointsC-1:0] updatedBranchMask_i [DispatchWidth],
  output issueQPacketT            issueQPacket_o [DispatchWidth],
  output alPacketT                alPacket_o [DispatchWidth],
  output lsqPacketT               lsqPacket_o [DispatchWidth],
  output logic                    dispatchValid_o
);

  issueQPacketT issueQPacketNext [DispatchWidth];
  alPacketT     alPacketNext [DispatchWidth];
  lsqPacketT    lsqPacketNext [DispatchWidth];

  always_comb begin
    for (int i = 0; i < DispatchWidth; i++) begin
      issueQPacketNext[i].destValid      = renamedPacket_i[i].destValid;
      issueQPacketNext[i].isStore        = renamedPacket_i[i].isStore;
      issueQPacketNext[i].isLoad         = renamedPacket_i[i].isLoad;
      issueQPacketNext[i].branchMask     = updatedBranchMask_i[i];  // Verified bit dropped
      issueQPacketNext[i].ctrlCheckpoint = renamedPacket_i[i].ctrlCheckpoint;
      issueQPacketNext[i].physSrc1       = renamedPacket_i[i].physSrc1;
      issueQPacketNext[i].physSrc2       = renamedPacket_i[i].physSrc2;
      issueQPacketNext[i].physDest       = renamedPacket_i[i].physDest;
      issueQPacketNext[i].physOldDest    = renamedPacket_i[i].physOldDest;
      issueQPacketNext[i].immValid       = renamedPacket_i[i].immValid;
      issueQPacketNext[i].imm            = renamedPacket_i[i].imm;
      issueQPacketNext[i].ldstSize       = renamedPacket_i[i].ldstSize;
      issueQPacketNext[i].instClass      = renamedPacket_i[i].instClass;
      issueQPacketNext[i].opcode         = renamedPacket_i[i].opcode;
      issueQPacketNext[i].pc             = renamedPacket_i[i].pc;
      issueQPacketNext[i].ctiTag         = renamedPacket_i[i].ctiTag;

      // Active list keeps what retire needs to commit or roll back
      alPacketNext[i].isLoad      = renamedPacket_i[i].isLoad;
      alPacketNext[i].isStore     = renamedPacket_i[i].isStore;
      alPacketNext[i].pc          = renamedPacket_i[i].pc;
      alPacketNext[i].archDest    = renamedPacket_i[i].archDest;
      alPacketNext[i].physDest    = renamedPacket_i[i].physDest;
      alPacketNext[i].physOldDest = renamedPacket_i[i].physOldDest;
      alPacketNext[i].destValid   = renamedPacket_i[i].destValid;

      lsqPacketNext[i].branchMask = updatedBranchMask_i[i];
      lsqPacketNext[i].isStore    = renamedPacket_i[i].isStore;
      lsqPacketNext[i].isLoad     = renamedPacket_i[i].isLoad;
    end
  end

  // Packets hold their last group, only the valid flag drops on idle cycles
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      dispatchValid_o <= 1'b0;
      for (int i = 0; i < DispatchWidth; i++) begin
        issueQPacket_o[i] <= '0;
        alPacket_o[i]     <= '0;
        lsqPacket_o[i]    <= '0;
      end
    end else begin
      dispatchValid_o <= dispatchEn_i;
      if (dispatchEn_i) begin
        for (int i = 0; i < DispatchWidth; i++) begin
          issueQPacket_o[i] <= issueQPacketNext[i];
          alPacket_o[i]     <= alPacketNext[i];
          lsqPacket_o[i]    <= lsqPacketNext[i];
        end
      end
    end
  end

endmodule

// ==== rtl/dispatchPkg.sv ====
// Dispatch field widths, instruction class enum and the renamed and back-end packet structs
package dispatchPkg;

  localparam int CheckpointsC   = 8;   // Branch checkpoints, also the mask width
  localparam int CheckpointLogW = 3;
  localparam int PhysRegLogW    = 7;   // Physical register tag
  localparam int ArchRegLogW    = 5;
  localparam int ImmW           = 16;
  localparam int OpcodeW        = 8;
  localparam int PcW            = 32;
  localparam int CtiTagW        = 4;
  localparam int CountW         = 8;   // Occupancy counts, capacities up to 255

  typedef enum logic [2:0] {
    ClassIntAlu     = 3'd0,
    ClassComplexAlu = 3'd1,
    ClassControl    = 3'd2,
    ClassLoadStore  = 3'd3,
    ClassNop        = 3'd4
  } instClassE;

  // One instruction as it leaves rename
  typedef struct packed {
    logic [ArchRegLogW-1:0]    archDest;
    logic                      destValid;
    logic                      isStore;
    logic                      isLoad;
    logic [CheckpointsC-1:0]   branchMask;     // Unresolved branches it depends on
    logic [CheckpointLogW-1:0] ctrlCheckpoint;
    logic [PhysRegLogW-1:0]    physSrc1;
    logic [PhysRegLogW-1:0]    physSrc2;
    logic [PhysRegLogW-1:0]    physDest;
    logic [PhysRegLogW-1:0]    physOldDest;    // Freed at retire
    logic                      immValid;
    logic [ImmW-1:0]           imm;
    logic [1:0]                ldstSize;
    instClassE                 instClass;
    logic [OpcodeW-1:0]        opcode;
    logic [PcW-1:0]            pc;
    logic [CtiTagW-1:0]        ctiTag;
  } renamedPacketT;

  // Same as renamed packet minus archDest
  typedef struct packed {
    logic                      destValid;
    logic                      isStore;
    logic                      isLoad;
    logic [CheckpointsC-1:0]   branchMask;
    logic [CheckpointLogW-1:0] ctrlCheckpoint;
    logic [PhysRegLogW-1:0]    physSrc1;
    logic [PhysRegLogW-1:0]    physSrc2;
    logic [PhysRegLogW-1:0]    physDest;
    logic [PhysRegLogW-1:0]    physOldDest;
    logic                      immValid;
    logic [ImmW-1:0]           imm;
    logic [1:0]                ldstSize;
    instClassE                 instClass;
    logic [OpcodeW-1:0]        opcode;
    logic [PcW-1:0]            pc;
    logic [CtiTagW-1:0]        ctiTag;
  } issueQPacketT;

  typedef struct packed {
    logic                   isLoad;
    logic                   isStore;
    logic [PcW-1:0]         pc;
    logic [ArchRegLogW-1:0] archDest;
    logic [PhysRegLogW-1:0] physDest;
    logic [PhysRegLogW-1:0] physOldDest;
    logic                   destValid;
  } alPacketT;

  typedef struct packed {
    logic [CheckpointsC-1:0] branchMask;
    logic                    isStore;
    logic                    isLoad;
  } lsqPacketT;

  typedef struct packed {
    logic                      valid;
    logic [CheckpointLogW-1:0] checkpoint;  // Branch found correct
  } ctrlVerifyT;

  typedef struct packed {
    logic [CountW-1:0] loadQueueCnt;
    logic [CountW-1:0] storeQueueCnt;
    logic [CountW-1:0] issueQueueCnt;
    logic [CountW-1:0] activeListCnt;
  } occupancyT;

endpackage

// ==== rtl/dispatchTop.sv ====
// Dispatch stage top level with branch mask update, resource check and packetizer
`timescale 1ns/1ps

module dispatchTop import dispatchPkg::*; #(
  parameter int DispatchWidth   = 4,
  parameter int LsqDepth        = 32,
  parameter int IssueQDepth     = 32,
  parameter int ActiveListDepth = 64
) (
  input  logic                    clk,
  input  logic                    rstN_i,
  input  renamedPacketT           renamedPacket_i [DispatchWidth],
  input  logic                    renameReady_i,   // Rename holds a full group
  input  logic                    flagRecoverEx_i,
  input  ctrlVerifyT              ctrlVerify_i,
  input  occupancyT               occupancy_i,
  output issueQPacketT            issueQPacket_o [DispatchWidth],
  output alPacketT                alPacket_o [DispatchWidth],
  output lsqPacketT               lsqPacket_o [DispatchWidth],
  output logic                    dispatchValid_o,
  output logic [CheckpointsC-1:0] updatedBranchMask_o [DispatchWidth],
  output logic                    backEndReady_o,
  output logic                    stallFrontEnd_o
);

  // Masks also go back toward the rename pipeline register
  branchMaskUpdate #(
    .DispatchWidth      (DispatchWidth)
  ) u_branchMaskUpdate (
    .renamedPacket_i    (renamedPacket_i),
    .ctrlVerify_i       (ctrlVerify_i),
    .updatedBranchMask_o(updatedBranchMask_o)
  );

  resourceCheck #(
    .DispatchWidth  (DispatchWidth),
    .LsqDepth       (LsqDepth),
    .IssueQDepth    (IssueQDepth),
    .ActiveListDepth(ActiveListDepth)
  ) u_resourceCheck (
    .renamedPacket_i(renamedPacket_i),
    .occupancy_i    (occupancy_i),
    .renameReady_i  (renameReady_i),
    .flagRecoverEx_i(flagRecoverEx_i),
    .backEndReady_o (backEndReady_o),
    .stallFrontEnd_o(stallFrontEnd_o)
  );

  dispatchPacketizer #(
    .DispatchWidth      (DispatchWidth)
  ) u_dispatchPacketizer (
    .clk                (clk),
    .rstN_i             (rstN_i),
    .dispatchEn_i       (backEndReady_o),  // Capture on every ready cycle
    .renamedPacket_i    (renamedPacket_i),
    .updatedBranchMask_i(updatedBranchMask_o),
    .issueQPacket_o     (issueQPacket_o),
    .alPacket_o         (alPacket_o),
    .lsqPacket_o        (lsqPacket_o),
    .dispatchValid_o    (dispatchValid_o)
  );

endmodule

// ==== rtl/resourceCheck.sv ====
// Load and store counting and back-end capacity check with ready and stall outputs
`timescale 1ns/1ps

module resourceCheck import dispatchPkg::*; #(
  parameter int DispatchWidth   = 4,
  parameter int LsqDepth        = 32,
  parameter int IssueQDepth     = 32,
  parameter int ActiveListDepth = 64
) (
  input  renamedPacketT renamedPacket_i [DispatchWidth],
  input  occupancyT     occupancy_i,
  input  logic          renameReady_i,
  input  logic          flagRecoverEx_i,
  output logic          backEndReady_o,
  output logic          stallFrontEnd_o
);

  localparam int GrpCntW = $clog2(DispatchWidth + 1);  // Holds 0..DispatchWidth
  localparam int SumW    = CountW + 1;                  // Count plus group, no wrap

  logic [GrpCntW-1:0] loadCnt;
  logic [GrpCntW-1:0] storeCnt;
  logic               loadStall;
  logic               storeStall;
  logic               issueQStall;
  logic               activeListStall;
  logic               resourceStall;

  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < DispatchWidth; i++) begin
      loadCnt  = loadCnt + GrpCntW'(renamedPacket_i[i].isLoad);
      storeCnt = storeCnt + GrpCntW'(renamedPacket_i[i].isStore);
    end
  end

  // Load and store queues only take what the group actually holds
  assign loadStall  = ({1'b0, occupancy_i.loadQueueCnt} + SumW'(loadCnt))
                      > SumW'(LsqDepth);
  assign storeStall = ({1'b0, occupancy_i.storeQueueCnt} + SumW'(storeCnt))
                      > SumW'(LsqDepth);

  // Issue queue and active list reserve a full group
  assign issueQStall     = ({1'b0, occupancy_i.issueQueueCnt} + SumW'(DispatchWidth))
                           > SumW'(IssueQDepth);
  assign activeListStall = ({1'b0, occupancy_i.activeListCnt} + SumW'(DispatchWidth))
                           > SumW'(ActiveListDepth);

  assign resourceStall   = loadStall | storeStall | issueQStall | activeListStall;

  assign stallFrontEnd_o = resourceStall;
  assign backEndReady_o  = renameReady_i & ~resourceStall & ~flagRecoverEx_i;

endmodule
